// File: Makefile
VERILATOR  := verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := mmu_tb
FILELIST   := sources.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/fault_stage.sv
module fault_stage (
    input  logic                aclk,
    input  logic                i_rst,

    xlate_if.dst                i_x,

    output logic                o_mem_valid,
    output mmu_pkg::paddr_t     o_mem_paddr,
    output logic                o_mem_write,
    output logic                o_mem_cached,

    output logic                o_fault_valid,
    output mmu_pkg::exc_code_t  o_fault_code,
    output mmu_pkg::vaddr_t     o_fault_vaddr
);
    import mmu_pkg::*;

    logic miss;
    logic modified;
    logic fault;
    exc_code_t code;
    paddr_t paddr;
    logic cached;

    // Refill and invalid report the same code on the data side
    assign miss = i_x.mapped && (!i_x.hit || !i_x.v);
    assign modified = i_x.mapped && i_x.write && !i_x.d;
    assign fault = i_x.addr_error || miss || modified;

    always_comb begin
        if (i_x.addr_error) begin
            code = i_x.write ? ADES : ADEL;
        end else if (miss) begin
            code = i_x.write ? TLBS : TLBL;
        end else begin
            code = MOD;
        end
    end

    // kseg0 and kseg1 both map onto the low 512 MB
    assign paddr = i_x.mapped ? {i_x.pfn, i_x.vaddr[PAGE_BITS-1:0]}
                              : {3'b000, i_x.vaddr[VADDR_W-4:0]};
    assign cached = i_x.mapped ? i_x.c : i_x.unmapped_cached;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            o_mem_valid <= 1'b0;
            o_fault_valid <= 1'b0;
        end else begin
            o_mem_valid <= i_x.valid && !fault;
            o_fault_valid <= i_x.valid && fault;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_x.valid) begin
            o_mem_paddr <= paddr;
            o_mem_write <= i_x.write;
            o_mem_cached <= cached;
            o_fault_code <= code;
            o_fault_vaddr <= i_x.vaddr; // Becomes BadVAddr in the core
        end
    end

endmodule

// File: logic/mmu_pkg.sv
package mmu_pkg;

    // Address and field widths
    localparam int VADDR_W = 32;
    localparam int PADDR_W = 32;
    localparam int PAGE_BITS = 12;
    localparam int VPN_W = VADDR_W - PAGE_BITS;
    localparam int PFN_W = PADDR_W - PAGE_BITS;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W = $clog2(TLB_ENTRIES);

    // Cycles with aresetn high before the subsystem leaves reset
    localparam int RESET_HOLD_CYCLES = 16;
    localparam int RESET_CNT_W = $clog2(RESET_HOLD_CYCLES);

    // kseg0 and kseg1 share the top two address bits, bit 29 tells them apart
    localparam logic [1:0] SEG_UNMAPPED = 2'b10;

    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [VPN_W-1:0] vpn_t;
    typedef logic [PFN_W-1:0] pfn_t;
    typedef logic [TLB_IDX_W-1:0] tlb_idx_t;

    // Cause register ExcCode values for the data side
    typedef enum logic [4:0] {
        MOD  = 5'd1, // Store to a clean page
        TLBL = 5'd2, // Load refill or invalid
        TLBS = 5'd3, // Store refill or invalid
        ADEL = 5'd4,
        ADES = 5'd5
    } exc_code_t;

endpackage

// File: logic/mmu_top.sv
module mmu_top (
    input  logic                aclk,
    input  logic                aresetn,

    input  logic                i_tlb_we,
    input  mmu_pkg::tlb_idx_t   i_tlb_index,
    input  mmu_pkg::vpn_t       i_tlb_vpn,
    input  mmu_pkg::pfn_t       i_tlb_pfn,
    input  logic                i_tlb_v,
    input  logic                i_tlb_d,
    input  logic                i_tlb_c,

    input  logic                i_req_valid,
    input  mmu_pkg::vaddr_t     i_req_vaddr,
    input  logic                i_req_write,
    input  logic                i_kernel_mode,

    output logic                o_ready,

    output logic                o_mem_valid,
    output mmu_pkg::paddr_t     o_mem_paddr,
    output logic                o_mem_write,
    output logic                o_mem_cached,

    output logic                o_fault_valid,
    output mmu_pkg::exc_code_t  o_fault_code,
    output mmu_pkg::vaddr_t     o_fault_vaddr
);
    import mmu_pkg::*;

    logic rst;
    vpn_t lvpn;
    logic tlb_hit;
    pfn_t tlb_pfn;
    logic tlb_v;
    logic tlb_d;
    logic tlb_c;

    xlate_if x_bus ();

    reset_stretch reset_stretch_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .o_rst   (rst),
        .o_ready (o_ready)
    );

    tlb_array tlb_array_i (
        .aclk   (aclk),
        .i_rst  (rst),
        .i_we   (i_tlb_we),
        .i_widx (i_tlb_index),
        .i_wvpn (i_tlb_vpn),
        .i_wpfn (i_tlb_pfn),
        .i_wv   (i_tlb_v),
        .i_wd   (i_tlb_d),
        .i_wc   (i_tlb_c),
        .i_lvpn (lvpn),
        .o_hit  (tlb_hit),
        .o_pfn  (tlb_pfn),
        .o_v    (tlb_v),
        .o_d    (tlb_d),
        .o_c    (tlb_c)
    );

    xlate_stage xlate_stage_i (
        .aclk          (aclk),
        .i_rst         (rst),
        .i_ready       (o_ready),
        .i_req_valid   (i_req_valid),
        .i_req_vaddr   (i_req_vaddr),
        .i_req_write   (i_req_write),
        .i_kernel_mode (i_kernel_mode),
        .o_lvpn        (lvpn),
        .i_hit         (tlb_hit),
        .i_pfn         (tlb_pfn),
        .i_v           (tlb_v),
        .i_d           (tlb_d),
        .i_c           (tlb_c),
        .o_x           (x_bus.src)
    );

    fault_stage fault_stage_i (
        .aclk          (aclk),
        .i_rst         (rst),
        .i_x           (x_bus.dst),
        .o_mem_valid   (o_mem_valid),
        .o_mem_paddr   (o_mem_paddr),
        .o_mem_write   (o_mem_write),
        .o_mem_cached  (o_mem_cached),
        .o_fault_valid (o_fault_valid),
        .o_fault_code  (o_fault_code),
        .o_fault_vaddr (o_fault_vaddr)
    );

endmodule

// File: logic/reset_stretch.sv
module reset_stretch (
    input  logic aclk,
    input  logic aresetn,
    output logic o_rst,
    output logic o_ready
);
    import mmu_pkg::*;

    logic [RESET_CNT_W-1:0] hold_cnt;
    logic rst_q;

    // Counts edges with aresetn high, any low edge starts the hold over
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            hold_cnt <= '0;
            rst_q <= 1'b1;
        end else if (rst_q) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == RESET_CNT_W'(RESET_HOLD_CYCLES - 1)) begin
                rst_q <= 1'b0; // Last edge of the hold
            end
        end
    end

    assign o_rst = rst_q;
    assign o_ready = ~rst_q;

endmodule

// File: logic/tlb_array.sv
module tlb_array (
    input  logic               aclk,
    input  logic               i_rst,

    input  logic               i_we,
    input  mmu_pkg::tlb_idx_t  i_widx,
    input  mmu_pkg::vpn_t      i_wvpn,
    input  mmu_pkg::pfn_t      i_wpfn,
    input  logic               i_wv,
    input  logic               i_wd,
    input  logic               i_wc,

    input  mmu_pkg::vpn_t      i_lvpn,

    output logic               o_hit,
    output mmu_pkg::pfn_t      o_pfn,
    output logic               o_v,
    output logic               o_d,
    output logic               o_c
);
    import mmu_pkg::*;

    vpn_t entry_vpn [TLB_ENTRIES];
    pfn_t entry_pfn [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] entry_v;
    logic [TLB_ENTRIES-1:0] entry_d;
    logic [TLB_ENTRIES-1:0] entry_c;

    // An entry only takes part in matching once it has been written
    logic [TLB_ENTRIES-1:0] entry_present;

    logic [TLB_ENTRIES-1:0] match;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            entry_present <= '0;
        end else if (i_we) begin
            entry_present[i_widx] <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_we) begin
            entry_vpn[i_widx] <= i_wvpn;
            entry_pfn[i_widx] <= i_wpfn;
            entry_v[i_widx] <= i_wv;
            entry_d[i_widx] <= i_wd;
            entry_c[i_widx] <= i_wc;
        end
    end

    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            match[i] = entry_present[i] && (entry_vpn[i] == i_lvpn);
        end
    end

    // Walks down so the lowest matching index is the last one assigned
    always_comb begin
        o_hit = 1'b0;
        o_pfn = '0;
        o_v = 1'b0;
        o_d = 1'b0;
        o_c = 1'b0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (match[i]) begin
                o_hit = 1'b1;
                o_pfn = entry_pfn[i];
                o_v = entry_v[i];
                o_d = entry_d[i];
                o_c = entry_c[i];
            end
        end
    end

endmodule

// File: logic/xlate_if.sv
interface xlate_if;
    import mmu_pkg::*;

    // Request as accepted by stage 1
    logic valid;
    vaddr_t vaddr;
    logic write;

    // Segment decode
    logic mapped;
    logic unmapped_cached; // kseg0 when set, kseg1 otherwise
    logic addr_error;

    // TLB lookup result captured with the request
    logic hit;
    pfn_t pfn;
    logic v;
    logic d;
    logic c;

    modport src (
        output valid, vaddr, write,
        output mapped, unmapped_cached, addr_error,
        output hit, pfn, v, d, c
    );

    modport dst (
        input valid, vaddr, write,
        input mapped, unmapped_cached, addr_error,
        input hit, pfn, v, d, c
    );

endinterface

// File: logic/xlate_stage.sv
module xlate_stage (
    input  logic              aclk,
    input  logic              i_rst,
    input  logic              i_ready,

    input  logic              i_req_valid,
    input  mmu_pkg::vaddr_t   i_req_vaddr,
    input  logic              i_req_write,
    input  logic              i_kernel_mode,

    output mmu_pkg::vpn_t     o_lvpn,

    input  logic              i_hit,
    input  mmu_pkg::pfn_t     i_pfn,
    input  logic              i_v,
    input  logic              i_d,
    input  logic              i_c,

    xlate_if.src              o_x
);
    import mmu_pkg::*;

    logic accept;
    logic seg_kernel;
    logic seg_unmapped;
    logic seg_cached;
    logic addr_error;

    assign accept = i_req_valid && i_ready;

    // The TLB is searched on the raw page number, segment decode runs alongside
    assign o_lvpn = i_req_vaddr[VADDR_W-1:PAGE_BITS];

    assign seg_kernel = i_req_vaddr[VADDR_W-1];
    assign seg_unmapped = i_req_vaddr[VADDR_W-1:VADDR_W-2] == SEG_UNMAPPED;
    assign seg_cached = seg_unmapped && !i_req_vaddr[VADDR_W-3]; // kseg0
    assign addr_error = seg_kernel && !i_kernel_mode;

    always_ff @(posedge aclk) begin
        if (i_rst) begin
            o_x.valid <= 1'b0;
        end else begin
            o_x.valid <= accept;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            o_x.vaddr <= i_req_vaddr;
            o_x.write <= i_req_write;
            o_x.mapped <= !seg_unmapped;
            o_x.unmapped_cached <= seg_cached;
            o_x.addr_error <= addr_error;
            o_x.hit <= i_hit;
            o_x.pfn <= i_pfn;
            o_x.v <= i_v;
            o_x.d <= i_d;
            o_x.c <= i_c;
        end
    end

endmodule

// File: sources.f
logic/mmu_pkg.sv
logic/xlate_if.sv
logic/reset_stretch.sv
logic/tlb_array.sv
logic/xlate_stage.sv
logic/fault_stage.sv
logic/mmu_top.sv
tests/mmu_props.sv
tests/mmu_tb.sv

// File: tests/mmu_props.sv
module mmu_props (
    input logic aclk,
    input logic aresetn,
    input logic i_req_valid,
    input logic i_ready,
    input logic i_mem_valid,
    input logic i_fault_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    logic result;
    logic accepted;

    assign result = i_mem_valid || i_fault_valid;
    assign accepted = i_req_valid && i_ready; // Requests while not ready are dropped

    one_pulse_kind: assert property (@(posedge aclk) disable iff (!aresetn)
        !(i_mem_valid && i_fault_valid))
        else $error("Memory request and fault pulse are high together");

    quiet_until_ready: assert property (@(posedge aclk) disable iff (!aresetn)
        !(result && !i_ready))
        else $error("Result pulse while the subsystem is not ready");

    result_has_request: assert property (@(posedge aclk) disable iff (!aresetn)
        result |-> $past(accepted, 2))
        else $error("Result pulse without an accepted request two cycles before");

    request_gets_result: assert property (@(posedge aclk) disable iff (!aresetn)
        accepted |-> ##2 result)
        else $error("Accepted request produced no result two cycles later");

endmodule

bind mmu_top mmu_props mmu_props_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .i_req_valid   (i_req_valid),
    .i_ready       (o_ready),
    .i_mem_valid   (o_mem_valid),
    .i_fault_valid (o_fault_valid)
);

// File: tests/mmu_tb.sv
module mmu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import mmu_pkg::*;

    localparam int NUM_ROWS = 22;
    localparam int WAIT_LIMIT = 64;

    typedef struct packed {
        logic [2:0] test;
        vaddr_t page;
        logic write;
        logic kernel;
        logic is_fault;
        exc_code_t code;
        paddr_t ppage;
        logic cached;
    } row_t;

    // Each queued result points back at its table row
    typedef struct packed {
        logic [31:0] due;
        logic [PAGE_BITS-1:0] offset;
        int row;
    } exp_t;

    // Each row holds test, page, write, kernel, fault, fault code, physical page and cached
    row_t rows [NUM_ROWS] = '{
        '{3'd1, 32'h0050_0000, 1'b0, 1'b0, 1'b1, TLBL, 32'h0000_0000, 1'b0}, // Entry 5 never landed
        '{3'd2, 32'h8001_0000, 1'b0, 1'b1, 1'b0, MOD, 32'h0001_0000, 1'b1},
        '{3'd2, 32'h9FFF_F000, 1'b1, 1'b1, 1'b0, MOD, 32'h1FFF_F000, 1'b1},
        '{3'd2, 32'hA002_0000, 1'b0, 1'b1, 1'b0, MOD, 32'h0002_0000, 1'b0},
        '{3'd2, 32'hBFC0_0000, 1'b1, 1'b1, 1'b0, MOD, 32'h1FC0_0000, 1'b0},
        '{3'd3, 32'h0040_0000, 1'b0, 1'b0, 1'b0, MOD, 32'h1234_5000, 1'b1}, // Entry 0 beats entry 3
        '{3'd3, 32'h0040_0000, 1'b1, 1'b0, 1'b0, MOD, 32'h1234_5000, 1'b1},
        '{3'd3, 32'hC000_0000, 1'b0, 1'b1, 1'b0, MOD, 32'h4444_4000, 1'b0},
        '{3'd3, 32'hC000_0000, 1'b1, 1'b1, 1'b0, MOD, 32'h4444_4000, 1'b0},
        '{3'd4, 32'h8000_1000, 1'b0, 1'b0, 1'b1, ADEL, 32'h0000_0000, 1'b0},
        '{3'd4, 32'h8000_1000, 1'b1, 1'b0, 1'b1, ADES, 32'h0000_0000, 1'b0},
        '{3'd4, 32'h0060_0000, 1'b0, 1'b0, 1'b1, TLBL, 32'h0000_0000, 1'b0},
        '{3'd4, 32'h0060_0000, 1'b1, 1'b0, 1'b1, TLBS, 32'h0000_0000, 1'b0},
        '{3'd4, 32'h0040_2000, 1'b0, 1'b0, 1'b1, TLBL, 32'h0000_0000, 1'b0}, // Entry 2 not valid
        '{3'd4, 32'h0040_1000, 1'b1, 1'b0, 1'b1, MOD, 32'h0000_0000, 1'b0},
        '{3'd4, 32'h0040_1000, 1'b0, 1'b0, 1'b0, MOD, 32'h2222_2000, 1'b0},
        '{3'd5, 32'h0040_1000, 1'b1, 1'b0, 1'b0, MOD, 32'h2222_2000, 1'b0},
        '{3'd6, 32'h0040_0000, 1'b0, 1'b0, 1'b0, MOD, 32'h1234_5000, 1'b1},
        '{3'd6, 32'hC000_0000, 1'b0, 1'b0, 1'b1, ADEL, 32'h0000_0000, 1'b0},
        '{3'd6, 32'hA000_0000, 1'b1, 1'b1, 1'b0, MOD, 32'h0000_0000, 1'b0},
        '{3'd6, 32'h0040_2000, 1'b1, 1'b0, 1'b1, TLBS, 32'h0000_0000, 1'b0},
        '{3'd6, 32'h0040_1000, 1'b1, 1'b1, 1'b0, MOD, 32'h2222_2000, 1'b0}
    };

    logic aclk, aresetn;
    logic i_tlb_we, i_tlb_v, i_tlb_d, i_tlb_c;
    tlb_idx_t i_tlb_index;
    vpn_t i_tlb_vpn;
    pfn_t i_tlb_pfn;
    logic i_req_valid, i_req_write, i_kernel_mode;
    vaddr_t i_req_vaddr;
    logic o_ready, o_mem_valid, o_mem_write, o_mem_cached, o_fault_valid;
    paddr_t o_mem_paddr;
    exc_code_t o_fault_code;
    vaddr_t o_fault_vaddr;

    exp_t exp_q [$];
    logic [31:0] cyc = '0;
    integer seed;
    int errors;
    int tests_failed;
    bit timed_out;

    mmu_top mmu_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) cyc <= cyc + 1'b1;

    task automatic check_paddr(input string name, input paddr_t got, input paddr_t exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_code(input string name, input exc_code_t got, input exc_code_t exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_vaddr(input string name, input vaddr_t got, input vaddr_t exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic set_tlb_write(input tlb_idx_t idx, input vpn_t vpn, input pfn_t pfn,
                                 input logic v, input logic d, input logic c);
        @(negedge aclk);
        i_tlb_we = 1'b1;
        i_tlb_index = idx;
        i_tlb_vpn = vpn;
        i_tlb_pfn = pfn;
        i_tlb_v = v;
        i_tlb_d = d;
        i_tlb_c = c;
    endtask

    task automatic apply_row(input int idx);
        logic [PAGE_BITS-1:0] off;
        off = PAGE_BITS'($random(seed));
        i_req_valid = 1'b1;
        i_req_vaddr = rows[idx].page | vaddr_t'(off);
        i_req_write = rows[idx].write;
        i_kernel_mode = rows[idx].kernel;
        exp_q.push_back(exp_t'{cyc + 32'd2, off, idx}); // Sampled next edge with the result one later
    endtask

    task automatic run_test(input int t, input string name, input int err_base);
        int n;
        if (!timed_out) begin
            for (int r = 0; r < NUM_ROWS; r++) begin
                if (rows[r].test == 3'(t)) begin
                    @(negedge aclk);
                    i_tlb_we = 1'b0;
                    apply_row(r);
                end
            end
            @(negedge aclk);
            i_req_valid = 1'b0;
            n = 0;
            while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
                @(posedge aclk);
                n++;
            end
            if (exp_q.size() != 0) begin
                $display("Timeout: test %0d still waits for %0d results", t, exp_q.size());
                timed_out = 1'b1;
            end
            if (errors != err_base || timed_out) begin
                tests_failed++;
            end
            $display("Test %0d %s: %0s with %0d errors", t, name,
                     (errors == err_base && !timed_out) ? "ok" : "failed", errors - err_base);
        end
    endtask

    // Outputs settle after the rising edge so they are read on the falling one
    always @(negedge aclk) begin : result_monitor
        row_t r;
        logic [PAGE_BITS-1:0] off;
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            r = rows[exp_q[0].row];
            off = exp_q[0].offset;
            void'(exp_q.pop_front());
            check_flag("o_fault_valid", o_fault_valid, r.is_fault);
            check_flag("o_mem_valid", o_mem_valid, !r.is_fault);
            if (r.is_fault) begin
                check_code("o_fault_code", o_fault_code, r.code);
                check_vaddr("o_fault_vaddr", o_fault_vaddr, r.page | vaddr_t'(off));
            end else begin
                check_paddr("o_mem_paddr", o_mem_paddr, r.ppage | paddr_t'(off));
                check_flag("o_mem_write", o_mem_write, r.write);
                check_flag("o_mem_cached", o_mem_cached, r.cached);
            end
        end else if (o_mem_valid === 1'b1 || o_fault_valid === 1'b1) begin
            $display("A result pulse came at cycle %0d with no request due", cyc);
            errors++;
        end
    end

    initial begin : main
        int n;
        int err_base;
        seed = 93598;
        errors = 0;
        tests_failed = 0;
        timed_out = 1'b0;
        aresetn = 1'b0;
        i_tlb_we = 1'b0;
        i_tlb_index = '0;
        i_tlb_vpn = '0;
        i_tlb_pfn = '0;
        i_tlb_v = 1'b0;
        i_tlb_d = 1'b0;
        i_tlb_c = 1'b0;
        i_req_valid = 1'b0;
        i_req_vaddr = '0;
        i_req_write = 1'b0;
        i_kernel_mode = 1'b0;
        repeat (3) @(negedge aclk);
        aresetn = 1'b1;
        err_base = errors;
        // Still inside the stretched reset, so the write and the request must vanish
        set_tlb_write(3'd5, 20'h00500, 20'h55555, 1'b1, 1'b1, 1'b1);
        i_req_valid = 1'b1;
        i_req_vaddr = 32'h8000_0040;
        i_kernel_mode = 1'b1;
        check_flag("o_ready", o_ready, 1'b0);
        @(negedge aclk);
        i_tlb_we = 1'b0;
        i_req_valid = 1'b0;
        n = 0;
        while (o_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (o_ready !== 1'b1) begin
            $display("Timeout: o_ready never rose after reset was released");
            timed_out = 1'b1;
        end else begin
            set_tlb_write(3'd0, 20'h00400, 20'h12345, 1'b1, 1'b1, 1'b1);
            set_tlb_write(3'd1, 20'h00401, 20'h22222, 1'b1, 1'b0, 1'b0);
            set_tlb_write(3'd2, 20'h00402, 20'h33333, 1'b0, 1'b1, 1'b1);
            set_tlb_write(3'd3, 20'h00400, 20'h77777, 1'b1, 1'b1, 1'b1);
            set_tlb_write(3'd4, 20'hC0000, 20'h44444, 1'b1, 1'b1, 1'b0);
        end
        run_test(1, "inputs before ready", err_base);
        run_test(2, "unmapped segments", errors);
        run_test(3, "mapped hits", errors);
        run_test(4, "fault codes", errors);
        err_base = errors;
        if (!timed_out) begin
            set_tlb_write(3'd1, 20'h00401, 20'h22222, 1'b1, 1'b1, 1'b0); // Page becomes dirty
        end
        run_test(5, "rewrite visibility", err_base);
        run_test(6, "back-to-back ordering", errors);
        $display("Tests run: 6, tests failed: %0d, errors: %0d", tests_failed, errors);
        if (timed_out || errors != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule
